// File: common/pipeline_params.svh
// Width, register count, memory tag and reset PC constants for the RV32 subset core
`ifndef PIPELINE_PARAMS_SVH
`define PIPELINE_PARAMS_SVH

// Data path and address width
`define XLEN 32

// Architectural registers, x0 included
`define NUM_REGS 32

// Bits needed to name one register
`define REG_IDX_W 5

// Memory tag width, tag zero never names a request
`define MEM_TAG_W 4

// Memory returns a double word per request
`define MEM_DATA_W 64

// Address of the first fetch after reset
`define RESET_PC 32'h0000_0000

`endif

// File: common/pipeline_pkg.sv
// Bus command, ALU operation, scalar and stage packet types for the RV32 subset core
`include "pipeline_params.svh"

package pipeline_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    // Zero reads as no tag
    typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

    // Memory command, same encoding as the full core minus stores
    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_command_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_BEQ  = 3'd5,
        ALU_BNE  = 3'd6,
        ALU_NONE = 3'd7
    } alu_op_t;

    // Fetch to decode, valid on top so an all-zero packet is a bubble
    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       npc;
        logic [31:0] inst;
    } if_packet_t;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    npc;
        alu_op_t  alu_op;
        reg_idx_t dest_idx;
        logic     wr_en;
        logic     use_imm;
        word_t    rs1_value;
        word_t    rs2_value;
        word_t    imm;
        word_t    branch_offset;
    } id_ex_packet_t;

    // Execute to complete, drives the register file and the commit ports
    typedef struct packed {
        logic     valid;
        word_t    npc;
        reg_idx_t dest_idx;
        logic     wr_en;
        word_t    result;
    } ex_co_packet_t;

endpackage

// File: fetch/instruction_fetch.sv
// Program counter, tagged memory request sequencing, tag matching and branch redirect
`include "pipeline_params.svh"

module instruction_fetch
    import pipeline_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   redirect,
    input  word_t                  redirect_pc,
    input  mem_tag_t               mem2proc_response,
    input  mem_tag_t               mem2proc_tag,
    input  logic [`MEM_DATA_W-1:0] mem2proc_data,
    output bus_command_t           proc2mem_command,
    output word_t                  proc2mem_addr,
    output if_packet_t             if_packet
);

    // Idle, waiting for acceptance, waiting for data
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_t;

    fetch_state_t state;
    word_t        pc;
    // Bus address, kept apart from pc so a redirect never moves a pending request
    word_t        req_addr;
    mem_tag_t     req_tag;
    logic         stale;
    logic         have_inst;
    logic [31:0]  inst_buf;
    logic         taken;
    logic         accepted;
    logic         tag_match;
    logic [31:0]  mem_inst;

    // Decode takes the packet whenever it is not stalled
    assign taken     = have_inst && !stall;
    assign accepted  = (state == FETCH_REQ) && (mem2proc_response != '0);
    assign tag_match = (state == FETCH_WAIT) && (mem2proc_tag == req_tag);
    // Address bit 2 picks the word inside the double word
    assign mem_inst  = req_addr[2] ? mem2proc_data[`MEM_DATA_W-1:`XLEN]
                                   : mem2proc_data[`XLEN-1:0];

    assign proc2mem_command = (state == FETCH_REQ) ? BUS_LOAD : BUS_NONE;
    assign proc2mem_addr    = req_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Request sequencing and PC
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            pc        <= `RESET_PC;
            req_addr  <= `RESET_PC;
            stale     <= 1'b0;
            have_inst <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    // One request at a time, only once the buffer is empty
                    if (!have_inst && !redirect) begin
                        state    <= FETCH_REQ;
                        req_addr <= pc;
                    end
                end
                FETCH_REQ: begin
                    if (accepted) begin
                        state <= FETCH_WAIT;
                    end
                    // Request keeps its address, its data gets thrown away
                    if (redirect) begin
                        stale <= 1'b1;
                    end
                end
                FETCH_WAIT: begin
                    if (tag_match) begin
                        state <= FETCH_IDLE;
                        stale <= 1'b0;
                        if (!stale && !redirect) begin
                            have_inst <= 1'b1;
                        end
                    end else if (redirect) begin
                        stale <= 1'b1;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase

            // Redirect drops the held packet and wins over an advance
            if (redirect) begin
                pc        <= redirect_pc;
                have_inst <= 1'b0;
            end else if (taken) begin
                pc        <= pc + word_t'(4);
                have_inst <= 1'b0;
            end
        end
    end

    // Tag and instruction payload
    always_ff @(posedge clock) begin
        if (accepted) begin
            req_tag <= mem2proc_response;
        end
        if (tag_match) begin
            inst_buf <= mem_inst;
        end
    end

    always_comb begin
        if_packet.valid = have_inst;
        if_packet.pc    = pc;
        if_packet.npc   = pc + word_t'(4);
        if_packet.inst  = inst_buf;
    end

endmodule

// File: flist.f
+incdir+common
common/pipeline_pkg.sv
fetch/instruction_fetch.sv
logic/pipeline_register.sv
logic/regfile.sv
logic/decode_issue.sv
logic/execute_stage.sv
logic/pipeline.sv
testbench/pipeline_assertions.sv
testbench/pipeline_tb.sv

// File: logic/decode_issue.sv
// Instruction decode, immediate generation, register read and read-after-write stall
`include "pipeline_params.svh"

module decode_issue
    import pipeline_pkg::*;
(
    input  if_packet_t    if_id,
    input  id_ex_packet_t id_ex,
    input  word_t         rf_data_1,
    input  word_t         rf_data_2,
    output reg_idx_t      rf_idx_1,
    output reg_idx_t      rf_idx_2,
    output logic          stall,
    output id_ex_packet_t id_packet
);

    // Major opcodes kept by this core
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    logic [31:0] inst;
    reg_idx_t    rd;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        writes_rd;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        producer;
    word_t       imm_i;
    word_t       imm_b;

    assign inst     = if_id.inst;
    assign rd       = inst[11:7];
    assign rf_idx_1 = inst[19:15];
    assign rf_idx_2 = inst[24:20];

    // Sign-extended I-type and B-type immediates
    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_b = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        alu_op = ALU_NONE;
        case (inst[6:0])
            OPCODE_OP: begin
                // funct7 and funct3 together
                case ({inst[31:25], inst[14:12]})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_111: alu_op = ALU_AND;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_100: alu_op = ALU_XOR;
                    default:         alu_op = ALU_NONE;
                endcase
            end
            OPCODE_OP_IMM: alu_op = (inst[14:12] == 3'b000) ? ALU_ADD : ALU_NONE;
            OPCODE_BRANCH: begin
                if (inst[14:12] == 3'b000) begin
                    alu_op = ALU_BEQ;
                end else if (inst[14:12] == 3'b001) begin
                    alu_op = ALU_BNE;
                end
            end
            default: alu_op = ALU_NONE;
        endcase
    end

    // Operand use follows from the op, unknown encodings read nothing
    assign use_imm   = (inst[6:0] == OPCODE_OP_IMM);
    assign writes_rd = (alu_op != ALU_NONE) && (alu_op != ALU_BEQ) && (alu_op != ALU_BNE);
    assign uses_rs1  = (alu_op != ALU_NONE);
    assign uses_rs2  = (alu_op != ALU_NONE) && !use_imm;

    // Only the instruction one stage ahead matters, older results come via write-through
    assign producer = id_ex.valid && id_ex.wr_en && (id_ex.dest_idx != '0);
    assign stall    = if_id.valid && producer &&
                      ((uses_rs1 && (rf_idx_1 == id_ex.dest_idx)) ||
                       (uses_rs2 && (rf_idx_2 == id_ex.dest_idx)));

    always_comb begin
        id_packet.valid         = if_id.valid && !stall;
        id_packet.pc            = if_id.pc;
        id_packet.npc           = if_id.npc;
        id_packet.alu_op        = alu_op;
        id_packet.dest_idx      = writes_rd ? rd : '0;
        id_packet.wr_en         = writes_rd && (rd != '0);
        id_packet.use_imm       = use_imm;
        id_packet.rs1_value     = rf_data_1;
        id_packet.rs2_value     = rf_data_2;
        id_packet.imm           = imm_i;
        id_packet.branch_offset = imm_b;
    end

endmodule

// File: logic/execute_stage.sv
// ALU, branch compare and taken-branch redirect for the RV32 subset core
module execute_stage
    import pipeline_pkg::*;
(
    input  id_ex_packet_t id_ex,
    output ex_co_packet_t ex_packet,
    output logic          redirect,
    output word_t         redirect_pc
);

    word_t opnd_a;
    word_t opnd_b;
    word_t result;
    logic  operands_equal;
    logic  branch_taken;

    // ADDI takes the immediate in place of rs2
    assign opnd_a         = id_ex.rs1_value;
    assign opnd_b         = id_ex.use_imm ? id_ex.imm : id_ex.rs2_value;
    assign operands_equal = (id_ex.rs1_value == id_ex.rs2_value);

    always_comb begin
        result       = '0;
        branch_taken = 1'b0;
        case (id_ex.alu_op)
            ALU_ADD: result = opnd_a + opnd_b;
            ALU_SUB: result = opnd_a - opnd_b;
            ALU_AND: result = opnd_a & opnd_b;
            ALU_OR:  result = opnd_a | opnd_b;
            ALU_XOR: result = opnd_a ^ opnd_b;
            // Branches compare the raw register values
            ALU_BEQ: branch_taken = operands_equal;
            ALU_BNE: branch_taken = !operands_equal;
            default: result = '0;
        endcase
    end

    // Bubbles never redirect
    assign redirect    = id_ex.valid && branch_taken;
    assign redirect_pc = id_ex.pc + id_ex.branch_offset;

    always_comb begin
        ex_packet.valid    = id_ex.valid;
        // Taken branch retires with its target as the next PC
        ex_packet.npc      = redirect ? redirect_pc : id_ex.npc;
        ex_packet.dest_idx = id_ex.dest_idx;
        // A stalled slot may still carry a write flag
        ex_packet.wr_en    = id_ex.valid && id_ex.wr_en;
        ex_packet.result   = result;
    end

endmodule

// File: logic/pipeline.sv
// Top level of the in-order RV32 subset core with fetch, stage registers and commit ports
`include "pipeline_params.svh"

module pipeline
    import pipeline_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  mem_tag_t               mem2proc_response,
    input  logic [`MEM_DATA_W-1:0] mem2proc_data,
    input  mem_tag_t               mem2proc_tag,
    output bus_command_t           proc2mem_command,
    output word_t                  proc2mem_addr,
    output logic                   commit_valid,
    output logic                   commit_wr_en,
    output reg_idx_t               commit_wr_idx,
    output word_t                  commit_wr_data,
    output word_t                  commit_NPC
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage wires
    ////////////////////////////////////////////////////////////////////////////

    if_packet_t    if_packet;
    if_packet_t    if_id_q;
    id_ex_packet_t id_packet;
    id_ex_packet_t id_ex_q;
    ex_co_packet_t ex_packet;
    ex_co_packet_t ex_co_q;

    logic     stall;
    logic     redirect;
    word_t    redirect_pc;
    reg_idx_t rf_idx_1;
    reg_idx_t rf_idx_2;
    word_t    rf_data_1;
    word_t    rf_data_2;

    instruction_fetch fetch_0 (
        .clock(clock),
        .reset(reset),
        .stall(stall),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .mem2proc_response(mem2proc_response),
        .mem2proc_tag(mem2proc_tag),
        .mem2proc_data(mem2proc_data),
        .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr),
        .if_packet(if_packet)
    );

    // IF/ID holds under a stall
    pipeline_register #(.payload_t(if_packet_t)) if_id_reg (
        .clock(clock),
        .reset(reset),
        .hold(stall),
        .flush(redirect),
        .d(if_packet),
        .q(if_id_q)
    );

    decode_issue decode_0 (
        .if_id(if_id_q),
        .id_ex(id_ex_q),
        .rf_data_1(rf_data_1),
        .rf_data_2(rf_data_2),
        .rf_idx_1(rf_idx_1),
        .rf_idx_2(rf_idx_2),
        .stall(stall),
        .id_packet(id_packet)
    );

    // Write port fed straight from EX/CO
    regfile regfile_0 (
        .clock(clock),
        .read_idx_1(rf_idx_1),
        .read_idx_2(rf_idx_2),
        .write_en(ex_co_q.wr_en),
        .write_idx(ex_co_q.dest_idx),
        .write_data(ex_co_q.result),
        .read_out_1(rf_data_1),
        .read_out_2(rf_data_2)
    );

    // Stall bubble arrives through d, not through hold
    pipeline_register #(.payload_t(id_ex_packet_t)) id_ex_reg (
        .clock(clock),
        .reset(reset),
        .hold(1'b0),
        .flush(redirect),
        .d(id_packet),
        .q(id_ex_q)
    );

    execute_stage execute_0 (
        .id_ex(id_ex_q),
        .ex_packet(ex_packet),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    // Never flushed, the taken branch itself lands here
    pipeline_register #(.payload_t(ex_co_packet_t)) ex_co_reg (
        .clock(clock),
        .reset(reset),
        .hold(1'b0),
        .flush(1'b0),
        .d(ex_packet),
        .q(ex_co_q)
    );

    // Commit ports
    assign commit_valid   = ex_co_q.valid;
    assign commit_wr_en   = ex_co_q.wr_en;
    assign commit_wr_idx  = ex_co_q.dest_idx;
    assign commit_wr_data = ex_co_q.result;
    assign commit_NPC     = ex_co_q.npc;

endmodule

// File: logic/pipeline_register.sv
// Type-parameterized stage register with synchronous reset, stall hold and flush
module pipeline_register #(
    // Stage packet, valid bit must read low when all bits are zero
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Reset and flush both leave a bubble
    // Flush beats hold so a taken branch clears a stalled stage too
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            q <= '0;
        end else if (!hold) begin
            // Normal advance
            q <= d;
        end
    end

endmodule

// File: logic/regfile.sv
// Architectural register file with x0 tied to zero and write-through reads
`include "pipeline_params.svh"

module regfile
    import pipeline_pkg::*;
(
    input  logic     clock,
    input  reg_idx_t read_idx_1,
    input  reg_idx_t read_idx_2,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  word_t    write_data,
    output word_t    read_out_1,
    output word_t    read_out_2
);

    word_t regs [`NUM_REGS];

    // x0 reads zero
    // Same-cycle write to the read index is forwarded
    assign read_out_1 = (read_idx_1 == '0) ? '0 :
                        (write_en && (write_idx == read_idx_1)) ? write_data : regs[read_idx_1];
    assign read_out_2 = (read_idx_2 == '0) ? '0 :
                        (write_en && (write_idx == read_idx_2)) ? write_data : regs[read_idx_2];

    // Writes to x0 dropped
    always_ff @(posedge clock) begin
        if (write_en && (write_idx != '0)) begin
            regs[write_idx] <= write_data;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f flist.f \
    --top-module pipeline_tb \
    -o pipeline_sim \
    && ./obj_dir/pipeline_sim \
    || { echo "simulation run failed"; exit 1; }

// File: testbench/pipeline_assertions.sv
// Bound checks on the commit ports and the tagged memory request port
module pipeline_assertions
    import pipeline_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input logic         commit_valid,
    input logic         commit_wr_en,
    input reg_idx_t     commit_wr_idx,
    input bus_command_t proc2mem_command,
    input word_t        proc2mem_addr,
    input mem_tag_t     mem2proc_response
);

    // A register write only comes with a retiring instruction
    wr_en_needs_valid: assert property (@(posedge clock) disable iff (reset)
        commit_wr_en |-> commit_valid)
        else $error("register write committed without a valid instruction");

    // x0 is never written
    no_write_to_x0: assert property (@(posedge clock) disable iff (reset)
        commit_wr_en |-> (commit_wr_idx != '0))
        else $error("register write committed to x0");

    // Address held until the memory gives a tag
    addr_stable_until_accept: assert property (@(posedge clock) disable iff (reset)
        (proc2mem_command == BUS_LOAD && mem2proc_response == '0) |=> $stable(proc2mem_addr))
        else $error("fetch address moved while a request waited for acceptance");

endmodule

bind pipeline pipeline_assertions assertions_0 (
    .clock(clock),
    .reset(reset),
    .commit_valid(commit_valid),
    .commit_wr_en(commit_wr_en),
    .commit_wr_idx(commit_wr_idx),
    .proc2mem_command(proc2mem_command),
    .proc2mem_addr(proc2mem_addr),
    .mem2proc_response(mem2proc_response)
);

// File: testbench/pipeline_tb.sv
// Testbench for the RV32 subset core: memory model, encoder, reference model, tests, watchdog
`include "pipeline_params.svh"

module pipeline_tb
    import pipeline_pkg::*;
();

    // Commits over all tests, plus slack for resets and the reset test
    localparam int TOTAL_COMMITS = 7 + 5 + 5 + 5 + 7;
    localparam int LIMIT_CYCLES  = 200 * TOTAL_COMMITS + 6 * 40;

    logic                   clock = 1'b0;
    logic                   reset = 1'b1;
    mem_tag_t               mem2proc_response = '0;
    mem_tag_t               mem2proc_tag = '0;
    logic [`MEM_DATA_W-1:0] mem2proc_data = '0;
    bus_command_t           proc2mem_command;
    word_t                  proc2mem_addr;
    logic                   commit_valid;
    logic                   commit_wr_en;
    reg_idx_t               commit_wr_idx;
    word_t                  commit_wr_data;
    word_t                  commit_NPC;

    // Instruction memory, 256 words
    logic [31:0] imem [256];

    // Expected commit stream
    logic     exp_wr_en [32];
    reg_idx_t exp_idx   [32];
    word_t    exp_data  [32];
    word_t    exp_npc   [32];

    logic [31:0] lfsr = 32'h744fb283;
    // Random bits per delay, 2 for normal memory and 3 for slow memory
    int          delay_bits = 2;

    pipeline dut (
        .clock(clock),
        .reset(reset),
        .mem2proc_response(mem2proc_response),
        .mem2proc_data(mem2proc_data),
        .mem2proc_tag(mem2proc_tag),
        .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr),
        .commit_valid(commit_valid),
        .commit_wr_en(commit_wr_en),
        .commit_wr_idx(commit_wr_idx),
        .commit_wr_data(commit_wr_data),
        .commit_NPC(commit_NPC)
    );

    always #5 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step for each bit taken
    task automatic random_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory model with tagged responses
    ////////////////////////////////////////////////////////////////////////////

    logic [1:0]  mem_state = 2'd0;
    logic [7:0]  mem_count = '0;
    word_t       mem_addr = '0;
    mem_tag_t    next_tag = 4'd1;

    always @(posedge clock) begin
        logic [7:0] rnd;
        // Response and tag are one-cycle pulses
        mem2proc_response <= '0;
        mem2proc_tag      <= '0;
        if (reset) begin
            mem_state <= 2'd0;
        end else begin
            case (mem_state)
                // Request seen, pick the acceptance delay
                2'd0: begin
                    if (proc2mem_command == BUS_LOAD) begin
                        random_bits(delay_bits, rnd);
                        mem_count <= rnd;
                        mem_state <= 2'd1;
                    end
                end
                2'd1: begin
                    if (mem_count == '0) begin
                        mem2proc_response <= next_tag;
                        mem_addr          <= proc2mem_addr;
                        random_bits(delay_bits, rnd);
                        mem_count         <= rnd;
                        mem_state         <= 2'd2;
                    end else begin
                        mem_count <= mem_count - 8'd1;
                    end
                end
                // Data returns with the tag given at acceptance
                2'd2: begin
                    if (mem_count == '0) begin
                        mem2proc_tag  <= next_tag;
                        mem2proc_data <= {imem[{mem_addr[9:3], 1'b1}],
                                          imem[{mem_addr[9:3], 1'b0}]};
                        next_tag      <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                        mem_state     <= 2'd0;
                    end else begin
                        mem_count <= mem_count - 8'd1;
                    end
                end
                default: mem_state <= 2'd0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
        logic [11:0] i12;
        i12 = 12'(imm);
        return {i12, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    // Offset in bytes from the branch itself
    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input int rs1,
                                               input int rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Runs the program in memory for n retirements
    task automatic build_expected(input int n);
        word_t       regs [32];
        word_t       pc;
        word_t       npc;
        word_t       a;
        word_t       b;
        word_t       val;
        word_t       imm_i;
        word_t       imm_b;
        logic [31:0] inst;
        logic        writes;
        reg_idx_t    rd;
        pc = `RESET_PC;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int k = 0; k < n; k++) begin
            inst   = imem[pc[9:2]];
            rd     = inst[11:7];
            a      = regs[inst[19:15]];
            b      = regs[inst[24:20]];
            imm_i  = {{20{inst[31]}}, inst[31:20]};
            imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            writes = 1'b0;
            val    = '0;
            npc    = pc + 32'd4;
            case (inst[6:0])
                7'b0110011: begin
                    writes = 1'b1;
                    case ({inst[31:25], inst[14:12]})
                        10'b0000000_000: val = a + b;
                        10'b0100000_000: val = a - b;
                        10'b0000000_111: val = a & b;
                        10'b0000000_110: val = a | b;
                        10'b0000000_100: val = a ^ b;
                        default:         writes = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    writes = (inst[14:12] == 3'b000);
                    val    = a + imm_i;
                end
                7'b1100011: begin
                    if ((inst[14:12] == 3'b000 && a == b) ||
                        (inst[14:12] == 3'b001 && a != b)) begin
                        npc = pc + imm_b;
                    end
                end
                default: writes = 1'b0;
            endcase
            exp_wr_en[k] = writes && (rd != '0);
            exp_idx[k]   = rd;
            exp_data[k]  = val;
            exp_npc[k]   = npc;
            if (exp_wr_en[k]) begin
                regs[rd] = val;
            end
            pc = npc;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t expected,
                             input reg_idx_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            $display("tests failed");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERR %s expected %b actual %b", name, expected, actual);
            $display("tests failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_command(input string name, input bus_command_t expected,
                                 input bus_command_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            $display("tests failed");
            $fatal(1, "bus command mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequencing
    ////////////////////////////////////////////////////////////////////////////

    // Reset held for 16 cycles while the new program is placed
    task automatic reset_and_load(input logic [31:0] prog[$]);
        @(posedge clock);
        reset <= 1'b1;
        // Unknown opcode in every fill word, the rest from the word address
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'h7f};
        end
        foreach (prog[i]) begin
            imem[i] = prog[i];
        end
        repeat (16) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic run_program(input string name, input logic [31:0] prog[$], input int n);
        int k;
        k = 0;
        reset_and_load(prog);
        build_expected(n);
        while (k < n) begin
            @(negedge clock);
            if (commit_valid) begin
                check_flag({name, " wr_en"}, exp_wr_en[k], commit_wr_en);
                if (exp_wr_en[k]) begin
                    check_idx({name, " wr_idx"}, exp_idx[k], commit_wr_idx);
                    check_word({name, " wr_data"}, exp_data[k], commit_wr_data);
                end
                check_word({name, " npc"}, exp_npc[k], commit_NPC);
                k++;
            end
        end
    endtask

    task automatic test_reset();
        logic [31:0] prog[$];
        prog = {enc_addi(1, 0, 1)};
        reset_and_load(prog);
        @(negedge clock);
        check_flag("reset commit_valid", 1'b0, commit_valid);
        check_flag("reset commit_wr_en", 1'b0, commit_wr_en);
        check_command("reset command", BUS_NONE, proc2mem_command);
        while (proc2mem_command != BUS_LOAD) begin
            check_flag("reset commit_valid", 1'b0, commit_valid);
            @(negedge clock);
        end
        check_word("reset first address", `RESET_PC, proc2mem_addr);
    endtask

    // Operands picked so no two ALU ops give the same result
    function automatic void chain_program(output logic [31:0] prog[$]);
        prog = {enc_addi(1, 0, 45),
                enc_r(7'b0000000, 3'b000, 2, 1, 1),
                enc_r(7'b0100000, 3'b000, 3, 1, 2),
                enc_r(7'b0000000, 3'b111, 4, 3, 2),
                enc_r(7'b0000000, 3'b110, 5, 4, 2),
                enc_r(7'b0000000, 3'b100, 6, 5, 3),
                enc_addi(7, 6, -100)};
    endfunction

    task automatic test_alu_chain(input string name);
        logic [31:0] prog[$];
        chain_program(prog);
        run_program(name, prog, 7);
    endtask

    task automatic test_x0_writes();
        logic [31:0] prog[$];
        prog = {enc_addi(1, 0, 9),
                enc_addi(0, 1, 7),
                enc_r(7'b0000000, 3'b000, 0, 1, 1),
                enc_r(7'b0000000, 3'b000, 2, 0, 1),
                enc_addi(3, 0, 0)};
        run_program("x0_writes", prog, 5);
    endtask

    // Two instructions after the BEQ are skipped
    task automatic test_taken_branch();
        logic [31:0] prog[$];
        prog = {enc_addi(1, 0, 4),
                enc_addi(2, 0, 4),
                enc_branch(3'b000, 1, 2, 12),
                enc_addi(3, 0, 1),
                enc_addi(4, 0, 2),
                enc_addi(5, 0, 3),
                enc_addi(6, 5, 1)};
        run_program("taken_branch", prog, 5);
    endtask

    // Not-taken BNE, a system opcode and an R-type with an unknown funct7
    task automatic test_not_taken_unknown();
        logic [31:0] prog[$];
        prog = {enc_addi(1, 0, 1),
                enc_branch(3'b001, 1, 1, 8),
                32'h0000_0073,
                enc_r(7'b0000001, 3'b000, 4, 1, 1),
                enc_addi(2, 1, 2)};
        run_program("not_taken_unknown", prog, 5);
    endtask

    // Watchdog sized from the expected commits
    initial begin
        #(LIMIT_CYCLES * 10);
        $display("Watchdog expired before the tests finished");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        test_reset();
        test_alu_chain("alu_chain");
        test_x0_writes();
        test_taken_branch();
        test_not_taken_unknown();
        delay_bits = 3;
        test_alu_chain("slow_memory");
        $display("all tests passed");
        $finish;
    end

endmodule
